// File: design/audio_pkg.sv
`default_nettype none

package audio_pkg;

    // One audio word, two's complement
    typedef logic signed [15:0] sample_t;

    // Gain of 64 passes the sample unchanged
    typedef logic [7:0] gain_t;

    // Four products of sample and gain fit with headroom
    typedef logic signed [25:0] acc_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam int N_MICS      = 4;
    localparam int UNITY_SHIFT = 6;

    // Register map, byte offsets
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_GAIN0  = 8'h04;
    localparam apb_addr_t REG_GAIN1  = 8'h08;
    localparam apb_addr_t REG_GAIN2  = 8'h0C;
    localparam apb_addr_t REG_GAIN3  = 8'h10;
    localparam apb_addr_t REG_FRAMES = 8'h14;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        SATURATE
    } mix_state_t;

endpackage

`default_nettype wire

// File: design/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
    input  wire                  clk,
    input  wire                  i_rst_n,
    input  wire                  i_psel,
    input  wire                  i_penable,
    input  wire                  i_pwrite,
    input  wire audio_pkg::apb_addr_t i_paddr,
    input  wire audio_pkg::apb_data_t i_pwdata,
    input  wire                  i_mix_done,
    output audio_pkg::apb_data_t o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    output logic                 o_enable,
    output logic [31:0]          o_gains
);

    audio_pkg::gain_t     gain_q [audio_pkg::N_MICS];
    audio_pkg::apb_data_t frame_cnt;
    audio_pkg::apb_data_t rd_data;
    logic                 addr_hit;
    logic                 gain_hit;
    logic [1:0]           gain_sel;
    logic                 setup_phase;
    logic                 wr_access;
    logic                 bad_access;

    assign o_pready    = 1'b1;
    assign setup_phase = i_psel && !i_penable;
    assign wr_access   = i_psel && i_penable && i_pwrite;
    assign bad_access  = !addr_hit || (i_pwrite && (i_paddr == audio_pkg::REG_FRAMES));

    // Address decode and read mux
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        gain_hit = 1'b0;
        gain_sel = 2'd0;
        case (i_paddr)
            audio_pkg::REG_CTRL:   rd_data = audio_pkg::apb_data_t'(o_enable);
            audio_pkg::REG_GAIN0:  gain_hit = 1'b1;
            audio_pkg::REG_GAIN1: begin
                gain_hit = 1'b1;
                gain_sel = 2'd1;
            end
            audio_pkg::REG_GAIN2: begin
                gain_hit = 1'b1;
                gain_sel = 2'd2;
            end
            audio_pkg::REG_GAIN3: begin
                gain_hit = 1'b1;
                gain_sel = 2'd3;
            end
            audio_pkg::REG_FRAMES: rd_data = frame_cnt;
            default:               addr_hit = 1'b0;
        endcase
        if (gain_hit) begin
            rd_data = audio_pkg::apb_data_t'(gain_q[gain_sel]);
        end
    end

    always_comb begin
        for (int m = 0; m < audio_pkg::N_MICS; m++) begin
            o_gains[m*8 +: 8] = gain_q[m];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_prdata  <= '0;
            o_pslverr <= 1'b0;
            o_enable  <= 1'b0;
            frame_cnt <= '0;
            for (int m = 0; m < audio_pkg::N_MICS; m++) begin
                gain_q[m] <= audio_pkg::gain_t'(1 << audio_pkg::UNITY_SHIFT);
            end
        end else begin
            // Error flag and read data valid in the access phase
            o_pslverr <= setup_phase && bad_access;
            if (setup_phase) begin
                o_prdata <= rd_data;
            end
            if (wr_access && (i_paddr == audio_pkg::REG_CTRL)) begin
                o_enable  <= i_pwdata[0];
                frame_cnt <= '0;
            end else if (i_mix_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (wr_access && gain_hit) begin
                gain_q[gain_sel] <= i_pwdata[7:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/i2s_mic_rx.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_mic_rx #(
    parameter int SCK_DIV = 4
) (
    input  wire         clk,
    input  wire         i_rst_n,
    input  wire         i_enable,
    input  wire  [3:0]  i_mic_sd,
    output logic        o_i2s_sck,
    output logic        o_i2s_ws,
    output logic        o_bit_fall,
    output logic        o_frame_valid,
    output logic [63:0] o_left,
    output logic [63:0] o_right
);

    localparam int HALF = SCK_DIV / 2;
    localparam int CW   = $clog2(SCK_DIV);

    logic [CW-1:0]      div_cnt;
    logic [4:0]         bit_cnt;
    logic               sck_rise;
    logic               sck_fall;
    audio_pkg::sample_t shreg [audio_pkg::N_MICS];

    // Each sck period starts low, rises halfway through
    assign sck_rise = i_enable && (div_cnt == CW'(HALF - 1));
    assign sck_fall = i_enable && (div_cnt == CW'(SCK_DIV - 1));

    // Left justified, so ws moves together with the MSB
    assign o_i2s_ws = bit_cnt[4];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt       <= '0;
            bit_cnt       <= '0;
            o_i2s_sck     <= 1'b0;
            o_bit_fall    <= 1'b0;
            o_frame_valid <= 1'b0;
        end else if (!i_enable) begin
            // Bus parked, next enable begins with the left slot
            div_cnt       <= '0;
            bit_cnt       <= '0;
            o_i2s_sck     <= 1'b0;
            o_bit_fall    <= 1'b0;
            o_frame_valid <= 1'b0;
        end else begin
            div_cnt       <= sck_fall ? '0 : div_cnt + 1'b1;
            o_bit_fall    <= sck_fall;
            o_frame_valid <= sck_rise && (bit_cnt == 5'd31);
            if (sck_rise) begin
                o_i2s_sck <= 1'b1;
            end
            if (sck_fall) begin
                o_i2s_sck <= 1'b0;
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end

    // Data sampled at the rising sck edge, words stored at slot ends
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            for (int m = 0; m < audio_pkg::N_MICS; m++) begin
                shreg[m] <= {shreg[m][14:0], i_mic_sd[m]};
                if (bit_cnt == 5'd15) begin
                    o_left[m*16 +: 16] <= {shreg[m][14:0], i_mic_sd[m]};
                end
                if (bit_cnt == 5'd31) begin
                    o_right[m*16 +: 16] <= {shreg[m][14:0], i_mic_sd[m]};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mic_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module mic_mixer (
    input  wire                clk,
    input  wire                i_rst_n,
    input  wire                i_enable,
    input  wire                i_frame_valid,
    input  wire  [63:0]        i_left,
    input  wire  [63:0]        i_right,
    input  wire  [31:0]        i_gains,
    output audio_pkg::sample_t o_mix_left,
    output audio_pkg::sample_t o_mix_right,
    output logic               o_mix_done
);

    localparam int IW = $clog2(audio_pkg::N_MICS);

    localparam audio_pkg::sample_t S_MAX = 16'sh7fff;
    localparam audio_pkg::sample_t S_MIN = 16'sh8000;

    audio_pkg::mix_state_t state;
    logic [IW-1:0]         mic_idx;
    logic                  prod_valid;
    logic                  prod_last;
    logic                  sum_done;
    logic                  shift_done;
    logic                  sat_done;
    audio_pkg::sample_t    cur_left;
    audio_pkg::sample_t    cur_right;
    audio_pkg::gain_t      cur_gain;
    audio_pkg::acc_t       prod_left;
    audio_pkg::acc_t       prod_right;
    audio_pkg::acc_t       acc_left;
    audio_pkg::acc_t       acc_right;
    audio_pkg::acc_t       shift_left;
    audio_pkg::acc_t       shift_right;
    audio_pkg::sample_t    sat_left;
    audio_pkg::sample_t    sat_right;

    function automatic audio_pkg::sample_t clamp(input audio_pkg::acc_t v);
        if (v > audio_pkg::acc_t'(S_MAX)) begin
            return S_MAX;
        end
        if (v < audio_pkg::acc_t'(S_MIN)) begin
            return S_MIN;
        end
        return v[15:0];
    endfunction

    // Operands of the microphone line in turn
    always_comb begin
        cur_left  = audio_pkg::sample_t'(i_left[mic_idx*16 +: 16]);
        cur_right = audio_pkg::sample_t'(i_right[mic_idx*16 +: 16]);
        cur_gain  = audio_pkg::gain_t'(i_gains[mic_idx*8 +: 8]);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= audio_pkg::IDLE;
            mic_idx    <= '0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            sum_done   <= 1'b0;
            shift_done <= 1'b0;
            sat_done   <= 1'b0;
            o_mix_done <= 1'b0;
        end else begin
            prod_valid <= (state == audio_pkg::ACCUM);
            prod_last  <= (state == audio_pkg::ACCUM) && (mic_idx == IW'(audio_pkg::N_MICS - 1));
            sum_done   <= prod_last;
            shift_done <= sum_done;
            sat_done   <= shift_done;
            o_mix_done <= sat_done;
            case (state)
                audio_pkg::IDLE: begin
                    if (i_frame_valid && i_enable) begin
                        state   <= audio_pkg::ACCUM;
                        mic_idx <= '0;
                    end
                end
                audio_pkg::ACCUM: begin
                    mic_idx <= mic_idx + 1'b1;
                    if (mic_idx == IW'(audio_pkg::N_MICS - 1)) begin
                        state <= audio_pkg::SATURATE;
                    end
                end
                audio_pkg::SATURATE: begin
                    // Shift and clamp stages drain before the next frame
                    if (sat_done) begin
                        state <= audio_pkg::IDLE;
                    end
                end
                default: state <= audio_pkg::IDLE;
            endcase
        end
    end

    // Product stage, accumulate, shift, clamp, output
    always_ff @(posedge clk) begin
        if (state == audio_pkg::ACCUM) begin
            prod_left  <= cur_left * $signed({1'b0, cur_gain});
            prod_right <= cur_right * $signed({1'b0, cur_gain});
        end
        if (state == audio_pkg::IDLE) begin
            acc_left  <= '0;
            acc_right <= '0;
        end else if (prod_valid) begin
            acc_left  <= acc_left + prod_left;
            acc_right <= acc_right + prod_right;
        end
        if (sum_done) begin
            shift_left  <= acc_left >>> audio_pkg::UNITY_SHIFT;
            shift_right <= acc_right >>> audio_pkg::UNITY_SHIFT;
        end
        if (shift_done) begin
            sat_left  <= clamp(shift_left);
            sat_right <= clamp(shift_right);
        end
        if (sat_done) begin
            o_mix_left  <= sat_left;
            o_mix_right <= sat_right;
        end
    end

endmodule

`default_nettype wire

// File: design/i2s_tx.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_tx (
    input  wire                clk,
    input  wire                i_rst_n,
    input  wire                i_bit_fall,
    input  wire                i_i2s_ws,
    input  wire                i_mix_done,
    input  wire audio_pkg::sample_t i_mix_left,
    input  wire audio_pkg::sample_t i_mix_right,
    output logic               o_dac_sd
);

    localparam int GAP_W = 10;

    audio_pkg::sample_t pend_left;
    audio_pkg::sample_t pend_right;
    logic               have_mix;
    logic               ws_last;
    logic               frame_start;
    logic               stalled;
    logic [31:0]        shreg;
    logic [GAP_W-1:0]   gap_cnt;
    logic [GAP_W-1:0]   bit_period;

    // ws falling at a bit boundary marks the left MSB
    assign frame_start = i_bit_fall && !i_i2s_ws && ws_last;

    // No bit edge within one measured period, bit clock has stopped
    assign stalled = gap_cnt > bit_period;

    assign o_dac_sd = shreg[31];

    always_ff @(posedge clk) begin
        if (i_mix_done) begin
            pend_left  <= i_mix_left;
            pend_right <= i_mix_right;
        end
    end

    // Bit period learned from the spacing of bit_fall pulses
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gap_cnt    <= '0;
            bit_period <= '1;
        end else if (i_bit_fall) begin
            gap_cnt <= '0;
            if (gap_cnt != '1) begin
                bit_period <= gap_cnt;
            end
        end else if (gap_cnt != '1) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            have_mix <= 1'b0;
            ws_last  <= 1'b0;
            shreg    <= '0;
        end else begin
            if (i_mix_done) begin
                have_mix <= 1'b1;
            end
            if (stalled) begin
                ws_last <= 1'b0;
                shreg   <= '0;
            end else if (i_bit_fall) begin
                ws_last <= i_i2s_ws;
                if (frame_start) begin
                    shreg <= have_mix ? {pend_left, pend_right} : '0;
                end else begin
                    shreg <= {shreg[30:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/audio_dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_dsp_top #(
    parameter int SCK_DIV = 4
) (
    input  wire                       clk,
    input  wire                       i_rst_n,
    // APB slave
    input  wire                       i_psel,
    input  wire                       i_penable,
    input  wire                       i_pwrite,
    input  wire audio_pkg::apb_addr_t i_paddr,
    input  wire audio_pkg::apb_data_t i_pwdata,
    output audio_pkg::apb_data_t      o_prdata,
    output logic                      o_pready,
    output logic                      o_pslverr,
    // Microphone I2S bus
    input  wire  [3:0]                i_mic_sd,
    output logic                      o_i2s_sck,
    output logic                      o_i2s_ws,
    // DAC data line, shares the microphone bit timing
    output logic                      o_dac_sd
);

    logic               enable;
    logic [31:0]        gains;
    logic               bit_fall;
    logic               frame_valid;
    logic [63:0]        mic_left;
    logic [63:0]        mic_right;
    audio_pkg::sample_t mix_left;
    audio_pkg::sample_t mix_right;
    logic               mix_done;

    apb_regs u_apb_regs (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .i_mix_done (mix_done),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_enable   (enable),
        .o_gains    (gains)
    );

    i2s_mic_rx #(
        .SCK_DIV (SCK_DIV)
    ) u_i2s_mic_rx (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (enable),
        .i_mic_sd      (i_mic_sd),
        .o_i2s_sck     (o_i2s_sck),
        .o_i2s_ws      (o_i2s_ws),
        .o_bit_fall    (bit_fall),
        .o_frame_valid (frame_valid),
        .o_left        (mic_left),
        .o_right       (mic_right)
    );

    // Weighted stereo sum of the eight channels
    mic_mixer u_mic_mixer (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (enable),
        .i_frame_valid (frame_valid),
        .i_left        (mic_left),
        .i_right       (mic_right),
        .i_gains       (gains),
        .o_mix_left    (mix_left),
        .o_mix_right   (mix_right),
        .o_mix_done    (mix_done)
    );

    i2s_tx u_i2s_tx (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_bit_fall  (bit_fall),
        .i_i2s_ws    (o_i2s_ws),
        .i_mix_done  (mix_done),
        .i_mix_left  (mix_left),
        .i_mix_right (mix_right),
        .o_dac_sd    (o_dac_sd)
    );

endmodule

`default_nettype wire

// File: dv/tb_audio_dsp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_audio_dsp;

    localparam int SCK_DIV  = 4;
    localparam int N_ROWS   = 8;
    localparam int N_FIXED  = 4;
    localparam int FRAME_CY = 32 * SCK_DIV;
    // Three frames per row plus register traffic and the extra tests
    localparam int WD_CYCLES = (N_ROWS * 4 + 12) * 40 * SCK_DIV;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [3:0]  mic_sd;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         sck;
    wire         ws;
    wire         dac_sd;

    // Stimulus table with expected mix
    logic [7:0]         t_gain  [N_ROWS][4];
    logic signed [15:0] t_left  [N_ROWS][4];
    logic signed [15:0] t_right [N_ROWS][4];
    logic [15:0]        t_exp_l [N_ROWS];
    logic [15:0]        t_exp_r [N_ROWS];

    int          errors;
    int          checks;
    int          cur_row;
    int          mic_pos;
    int          mic_frames;
    int          dac_pos;
    logic        sck_q;
    logic [31:0] dac_shift;
    logic [31:0] dac_frames [$];

    audio_dsp_top #(
        .SCK_DIV (SCK_DIV)
    ) dut (
        .clk       (clk),
        .i_rst_n   (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr),
        .i_mic_sd  (mic_sd),
        .o_i2s_sck (sck),
        .o_i2s_ws  (ws),
        .o_dac_sd  (dac_sd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Weighted sum shifted right by 6 and clamped to 16 bits
    function automatic logic [15:0] mix_expect(input int row, input bit right);
        int sum;
        int s;
        int g;
        sum = 0;
        for (int m = 0; m < 4; m++) begin
            s = right ? int'(t_right[row][m]) : int'(t_left[row][m]);
            g = int'(t_gain[row][m]);
            sum += s * g;
        end
        sum = sum >>> 6;
        if (sum > 32767) sum = 32767;
        if (sum < -32768) sum = -32768;
        return sum[15:0];
    endfunction

    // Four line bits for a frame position with the left word ahead of the right
    function automatic logic [3:0] mic_bits(input int row, input int pos);
        logic [3:0]  b;
        logic [15:0] w;
        for (int m = 0; m < 4; m++) begin
            w = (pos < 16) ? t_left[row][m] : t_right[row][m];
            b[m] = w[15 - (pos % 16)];
        end
        return b;
    endfunction

    // Microphone model drives on sck falls and the DAC capture samples on sck rises
    always @(posedge clk) begin
        sck_q <= sck;
        if (sck_q && !sck) begin
            if (mic_pos == 31) begin
                mic_pos    <= 0;
                mic_frames <= mic_frames + 1;
                mic_sd     <= mic_bits(cur_row, 0);
            end else begin
                mic_pos <= mic_pos + 1;
                mic_sd  <= mic_bits(cur_row, mic_pos + 1);
            end
        end
        if (!sck_q && sck) begin
            // Left slot while ws is low
            check("ws", ws, dac_pos >= 16);
            dac_shift <= {dac_shift[30:0], dac_sd};
            if (dac_pos == 31) begin
                dac_pos <= 0;
                dac_frames.push_back({dac_shift[30:0], dac_sd});
            end else begin
                dac_pos <= dac_pos + 1;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        err = pslverr;
        check("pready", pready, 1);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        check("pready", pready, 1);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic watch_quiet(input int cycles, input string name);
        int bad;
        bad = 0;
        repeat (cycles) begin
            @(posedge clk);
            if (sck !== 1'b0 || dac_sd !== 1'b0) bad++;
        end
        check(name, bad, 0);
    endtask

    task automatic wait_dac(input int n);
        int cnt;
        cnt = 0;
        while (dac_frames.size() < n && cnt < 4 * FRAME_CY + 50) begin
            @(posedge clk);
            cnt++;
        end
        if (dac_frames.size() < n) begin
            errors++;
            $display("No DAC frame %0d arrived in time, row %0d", n, cur_row);
        end
    endtask

    // Rewind the models while the bus is parked
    task automatic restart_models();
        @(posedge clk);
        mic_pos <= 0;
        dac_pos <= 0;
        mic_sd  <= mic_bits(cur_row, 0);
        dac_frames.delete();
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s finished, %0d errors so far", num, name, errors);
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired, the run took longer than the tests allow");
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        logic        err;
        int          seen;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        mic_sd     = '0;
        rst_n      = 1'b0;
        errors     = 0;
        checks     = 0;
        cur_row    = 0;
        mic_pos    = 0;
        mic_frames = 0;
        dac_pos    = 0;
        sck_q      = 1'b0;
        dac_shift  = '0;
        void'($urandom(32'hf090_6fd4));

        // Fixed rows for unity, clipping, zero gain and mixed gains
        for (int m = 0; m < 4; m++) begin
            t_gain[0][m] = 8'd64;
            t_left[0][m] = 16'(100 * (m + 1));
            t_right[0][m] = -16'(m + 1);
            t_gain[1][m] = 8'd64;
            t_left[1][m] = 16'sd20000;
            t_right[1][m] = -16'sd20000;
            t_gain[2][m] = 8'd0;
            t_left[2][m] = 16'sd12345;
            t_right[2][m] = -16'sd321;
            t_left[3][m] = 16'(1000 * m - 1500);
            t_right[3][m] = 16'(-700 * m + 90);
        end
        t_gain[3][0] = 8'd128;
        t_gain[3][1] = 8'd32;
        t_gain[3][2] = 8'd255;
        t_gain[3][3] = 8'd1;
        for (int r = N_FIXED; r < N_ROWS; r++) begin
            for (int m = 0; m < 4; m++) begin
                rnd = $urandom;
                t_left[r][m] = rnd[15:0];
                t_right[r][m] = rnd[31:16];
                rnd = $urandom;
                t_gain[r][m] = rnd[7:0];
            end
        end
        for (int r = 0; r < N_ROWS; r++) begin
            t_exp_l[r] = mix_expect(r, 1'b0);
            t_exp_r[r] = mix_expect(r, 1'b1);
        end

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(8'h00, rd, err);
        check("ctrl", rd, 0);
        for (int m = 0; m < 4; m++) begin
            apb_read(8'h04 + 8'(4 * m), rd, err);
            check("gain", rd, 64);
        end
        apb_read(8'h14, rd, err);
        check("frames", rd, 0);
        watch_quiet(FRAME_CY, "sck_dac_idle");
        report_test(1, "reset values");

        apb_write(8'h08, 32'h5a, err);
        check("pslverr", err, 0);
        apb_read(8'h08, rd, err);
        check("gain1", rd, 32'h5a);
        apb_read(8'h20, rd, err);
        check("pslverr", err, 1);
        check("unmapped", rd, 0);
        apb_write(8'h14, 32'h1234, err);
        check("pslverr", err, 1);
        apb_read(8'h14, rd, err);
        check("frames", rd, 0);
        report_test(2, "register access");

        for (int r = 0; r < N_ROWS; r++) begin
            apb_write(8'h00, 32'h0, err);
            repeat (8) @(posedge clk);
            for (int m = 0; m < 4; m++) begin
                apb_write(8'h04 + 8'(4 * m), 32'(t_gain[r][m]), err);
            end
            cur_row = r;
            restart_models();
            apb_write(8'h00, 32'h1, err);
            // Mix of frame 0 goes out in frame 2
            wait_dac(3);
            if (dac_frames.size() >= 3) begin
                check("dac_left", 32'(dac_frames[2][31:16]), 32'(t_exp_l[r]));
                check("dac_right", 32'(dac_frames[2][15:0]), 32'(t_exp_r[r]));
            end
            report_test(3 + r, "mix row");
        end

        apb_write(8'h00, 32'h1, err);
        seen = mic_frames;
        while (mic_frames < seen + 5) @(posedge clk);
        apb_read(8'h14, rd, err);
        check("frames_near_5", (rd >= 4 && rd <= 6), 1);
        apb_write(8'h00, 32'h0, err);
        apb_read(8'h14, rd, err);
        check("frames_cleared", rd, 0);
        report_test(3 + N_ROWS, "frame counter");

        repeat (8) @(posedge clk);
        watch_quiet(FRAME_CY, "sck_dac_disabled");
        report_test(4 + N_ROWS, "disable");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/audio_pkg.sv
design/apb_regs.sv
design/i2s_mic_rx.sv
design/mic_mixer.sv
design/i2s_tx.sv
design/audio_dsp_top.sv
dv/tb_audio_dsp.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, the log decides the result
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_audio_dsp \
    -o sim_audio && ./obj_dir/sim_audio > sim.log 2>&1 || {
    echo "Build or run error"
    exit 1
}
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
